/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       := tb_dot_matrix_panel
FILELIST  := dot_matrix_panel.f
OBJDIR    := obj_dir
LOG       := sim.log
FAIL_MSG  := Simulation failed
PASS_MSG  := Simulation passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	-./$(OBJDIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "run FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "run ended without a result"; exit 1; fi
	@echo "run OK"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* design/dot_matrix_defs.svh */
`ifndef DOT_MATRIX_DEFS_SVH
`define DOT_MATRIX_DEFS_SVH

// rows on the panel
`define DM_ROWS 8

// clk cycles spent on each row
`define DM_SCAN_DIV 4

`endif

/* design/dot_matrix_panel.sv */
`timescale 1ns/1ps
`include "dot_matrix_defs.svh"

module dot_matrix_panel #(
    parameter int scan_div = `DM_SCAN_DIV
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       st,
    input  logic       temp,
    input  logic [3:0] num,
    output logic [7:0] row,
    output logic [7:0] colr,
    output logic [7:0] colg
);

    logic                     tick;
    logic                     load;
    logic                     frame_load;
    dot_matrix_pkg::row_idx_t row_next;

    // row pacing
    scan_tick_gen #(
        .div (scan_div)
    ) u_tick (
        .clk  (clk),
        .rst  (rst),
        .tick (tick)
    );

    row_scanner u_scan (
        .clk        (clk),
        .rst        (rst),
        .tick       (tick),
        .load       (load),
        .row_next   (row_next),
        .frame_load (frame_load),
        .row        (row)
    );

    glyph_columns u_glyph (
        .clk        (clk),
        .rst        (rst),
        .load       (load),
        .row_next   (row_next),
        .frame_load (frame_load),
        .st         (st),
        .temp       (temp),
        .num        (num),
        .colg       (colg),
        .colr       (colr)
    );

endmodule

/* design/dot_matrix_pkg.sv */
package dot_matrix_pkg;

    // row number on the panel, row 0 is the top line
    typedef logic [2:0] row_idx_t;

    // one byte of column bits, bit 7 is the leftmost LED
    // also reused for the active-low row drive
    typedef logic [7:0] col_t;

    // fill level from the level source
    typedef logic [3:0] level_t;

    // glyph selected for a frame
    typedef enum logic [3:0] {
        GLYPH_L0    = 4'd0,
        GLYPH_L1    = 4'd1,
        GLYPH_L2    = 4'd2,
        GLYPH_L3    = 4'd3,
        GLYPH_L4    = 4'd4,
        GLYPH_L5    = 4'd5,
        GLYPH_L6    = 4'd6,
        GLYPH_L7    = 4'd7,
        GLYPH_BLANK = 4'd15  // levels 8..15
    } glyph_e;

endpackage

/* design/glyph_columns.sv */
`timescale 1ns/1ps

module glyph_columns (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     load,
    input  dot_matrix_pkg::row_idx_t row_next,
    input  logic                     frame_load,
    input  logic                     st,
    input  logic                     temp,
    input  dot_matrix_pkg::level_t   num,
    output dot_matrix_pkg::col_t     colg,
    output dot_matrix_pkg::col_t     colr
);

    dot_matrix_pkg::level_t frame_level;
    dot_matrix_pkg::level_t cur_level;
    dot_matrix_pkg::glyph_e glyph;
    dot_matrix_pkg::col_t   col_bits;

    function automatic dot_matrix_pkg::glyph_e level_to_glyph(
        input dot_matrix_pkg::level_t lvl
    );
        dot_matrix_pkg::glyph_e g;
        case (lvl)
            4'd0:    g = dot_matrix_pkg::GLYPH_L0;
            4'd1:    g = dot_matrix_pkg::GLYPH_L1;
            4'd2:    g = dot_matrix_pkg::GLYPH_L2;
            4'd3:    g = dot_matrix_pkg::GLYPH_L3;
            4'd4:    g = dot_matrix_pkg::GLYPH_L4;
            4'd5:    g = dot_matrix_pkg::GLYPH_L5;
            4'd6:    g = dot_matrix_pkg::GLYPH_L6;
            4'd7:    g = dot_matrix_pkg::GLYPH_L7;
            default: g = dot_matrix_pkg::GLYPH_BLANK;
        endcase
        return g;
    endfunction

    function automatic dot_matrix_pkg::col_t glyph_row(
        input dot_matrix_pkg::glyph_e   g,
        input dot_matrix_pkg::row_idx_t r
    );
        dot_matrix_pkg::col_t c;
        c = 8'h00;
        case (g)
            dot_matrix_pkg::GLYPH_L0:
                case (r)
                    3'd2, 3'd5: c = 8'h18;
                    3'd3, 3'd4: c = 8'h3c;
                    default:    c = 8'h00;
                endcase
            dot_matrix_pkg::GLYPH_L1:
                case (r)
                    3'd2, 3'd5: c = 8'h38;
                    3'd3, 3'd4: c = 8'h7c;
                    default:    c = 8'h00;
                endcase
            dot_matrix_pkg::GLYPH_L2:
                case (r)
                    3'd2, 3'd5: c = 8'h3c;
                    3'd3, 3'd4: c = 8'h7e;
                    default:    c = 8'h00;
                endcase
            dot_matrix_pkg::GLYPH_L3:
                case (r)
                    3'd1, 3'd6:             c = 8'h3c;
                    3'd2, 3'd3, 3'd4, 3'd5: c = 8'h7e;
                    default:                c = 8'h00;
                endcase
            dot_matrix_pkg::GLYPH_L4:
                case (r)
                    3'd0, 3'd7: c = 8'h3c;
                    3'd1, 3'd6: c = 8'h7e;
                    default:    c = 8'hff;  // rows 2..5
                endcase
            dot_matrix_pkg::GLYPH_L5:
                c = 8'hff;  // full panel
            dot_matrix_pkg::GLYPH_L6:
                case (r)
                    3'd0: c = 8'hc3;
                    3'd1: c = 8'he3;
                    3'd2: c = 8'hf1;
                    3'd3: c = 8'he3;
                    3'd4: c = 8'hc7;
                    3'd5: c = 8'he7;
                    3'd6: c = 8'hf7;
                    3'd7: c = 8'hfb;
                endcase
            dot_matrix_pkg::GLYPH_L7:
                case (r)
                    3'd0: c = 8'h00;
                    3'd1: c = 8'h01;
                    3'd2: c = 8'h81;
                    3'd3: c = 8'hc3;
                    3'd4: c = 8'h83;
                    3'd5: c = 8'hc7;
                    3'd6: c = 8'he7;
                    3'd7: c = 8'hf3;
                endcase
            default:
                c = 8'h00;
        endcase
        return c;
    endfunction

    // on the row 0 strobe the fresh sample is used directly
    assign cur_level = frame_load ? num : frame_level;

    always_comb
    begin
        glyph    = level_to_glyph(cur_level);
        col_bits = glyph_row(glyph, row_next);
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            frame_level <= '0;
            colg        <= '0;
            colr        <= '0;
        end
        else if (!st)
        begin
            // display off, blank at once
            frame_level <= '0;
            colg        <= '0;
            colr        <= '0;
        end
        else
        begin
            if (frame_load)
                frame_level <= num;
            if (load)
            begin
                colg <= col_bits;
                colr <= temp ? col_bits : '0;  // alarm mirrors green onto red
            end
            else if (!temp)
                colr <= '0;
        end
    end

    a_red_needs_temp: assert property (
        @(posedge clk) disable iff (rst)
        !temp |=> (colr == '0)
    );

    // red only ever lights where green is lit
    a_red_within_green: assert property (
        @(posedge clk) disable iff (rst)
        (colr & ~colg) == '0
    );

endmodule

/* design/row_scanner.sv */
`timescale 1ns/1ps
`include "dot_matrix_defs.svh"

module row_scanner (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    tick,
    output logic                    load,
    output dot_matrix_pkg::row_idx_t row_next,
    output logic                    frame_load,
    output dot_matrix_pkg::col_t    row
);

    dot_matrix_pkg::row_idx_t row_idx;
    logic                     scan_on;  // set after the first strobe

    // starts at the last row so the first strobe lands on row 0
    assign row_next = (row_idx == dot_matrix_pkg::row_idx_t'(`DM_ROWS - 1))
                      ? '0 : row_idx + dot_matrix_pkg::row_idx_t'(1);

    assign load       = tick;
    assign frame_load = tick && (row_next == '0);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row_idx <= dot_matrix_pkg::row_idx_t'(`DM_ROWS - 1);
            row     <= '1;  // no row driven
            scan_on <= 1'b0;
        end
        else if (tick)
        begin
            row_idx <= row_next;
            row     <= ~(dot_matrix_pkg::col_t'(1) << row_next);
            scan_on <= 1'b1;
        end
    end

    // once scanning, exactly one row line is pulled low
    a_row_onehot: assert property (
        @(posedge clk) disable iff (rst)
        scan_on |-> $onehot(~row)
    );

endmodule

/* design/scan_tick_gen.sv */
`timescale 1ns/1ps
`include "dot_matrix_defs.svh"

module scan_tick_gen #(
    parameter int div = `DM_SCAN_DIV
) (
    input  logic clk,
    input  logic rst,
    output logic tick
);

    localparam int cw = (div > 1) ? $clog2(div) : 1;

    logic [cw-1:0] cnt;

    // down counter, tick is registered so it is low out of reset
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            cnt  <= cw'(div - 1);
            tick <= 1'b0;
        end
        else
        begin
            if (cnt == '0)
                cnt <= cw'(div - 1);  // reload
            else
                cnt <= cnt - 1'b1;
            tick <= (cnt == '0);
        end
    end

    // strobe is a single cycle pulse for any real divider
    a_tick_single: assert property (
        @(posedge clk) disable iff (rst)
        (div > 1) && tick |=> !tick
    );

endmodule

/* dot_matrix_panel.f */
+incdir+design
design/dot_matrix_pkg.sv
design/scan_tick_gen.sv
design/row_scanner.sv
design/glyph_columns.sv
design/dot_matrix_panel.sv
verif/tb_dot_matrix_panel.sv

/* verif/tb_dot_matrix_panel.sv */
`timescale 1ns/1ps
`include "dot_matrix_defs.svh"

module tb_dot_matrix_panel;

    localparam int scan_div = 3;
    localparam int wait_limit = 100;  // cycles

    logic       clk = 1'b0;
    logic       rst;
    logic       st;
    logic       temp;
    logic [3:0] num;
    logic [7:0] row;
    logic [7:0] colr;
    logic [7:0] colg;

    // model state updated once per cycle at negedge
    logic                     rst_d = 1'b1;
    logic                     st_d = 1'b0;
    logic                     temp_d = 1'b0;
    dot_matrix_pkg::level_t   num_d = '0;
    logic                     started = 1'b0;
    int                       gap = 0;
    dot_matrix_pkg::row_idx_t exp_idx = '0;
    dot_matrix_pkg::col_t     exp_row = '1;
    dot_matrix_pkg::col_t     exp_g = '0;
    dot_matrix_pkg::col_t     exp_r = '0;
    dot_matrix_pkg::level_t   lvl_m = '0;

    dot_matrix_panel #(
        .scan_div (scan_div)
    ) u_dut (
        .clk  (clk),
        .rst  (rst),
        .st   (st),
        .temp (temp),
        .num  (num),
        .row  (row),
        .colr (colr),
        .colg (colg)
    );

    always #5 clk = ~clk;

    task automatic stop_with_failure();
        $display("Simulation failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_row(
        input string                name,
        input dot_matrix_pkg::col_t exp_v,
        input dot_matrix_pkg::col_t act_v
    );
        if (act_v !== exp_v)
        begin
            $display("[FAIL] t=%0t %s expected %b actual %b", $time, name, exp_v, act_v);
            stop_with_failure();
        end
    endtask

    task automatic check_cols(
        input string                name,
        input dot_matrix_pkg::col_t exp_v,
        input dot_matrix_pkg::col_t act_v
    );
        if (act_v !== exp_v)
        begin
            $display("[FAIL] t=%0t %s expected %h actual %h", $time, name, exp_v, act_v);
            stop_with_failure();
        end
    endtask

    task automatic check_level(
        input string                  name,
        input dot_matrix_pkg::level_t exp_v,
        input dot_matrix_pkg::level_t act_v
    );
        if (act_v !== exp_v)
        begin
            $display("[FAIL] t=%0t %s expected %0d actual %0d", $time, name, exp_v, act_v);
            stop_with_failure();
        end
    endtask

    // glyph table with row 0 in the top byte
    function automatic dot_matrix_pkg::col_t glyph_ref(
        input dot_matrix_pkg::level_t   level,
        input dot_matrix_pkg::row_idx_t r
    );
        dot_matrix_pkg::glyph_e g;
        logic [63:0]            rows;
        int                     sh;
        g = (level > 4'd7) ? dot_matrix_pkg::GLYPH_BLANK : dot_matrix_pkg::glyph_e'(level);
        case (g)
            dot_matrix_pkg::GLYPH_L0: rows = 64'h0000_183c_3c18_0000;
            dot_matrix_pkg::GLYPH_L1: rows = 64'h0000_387c_7c38_0000;
            dot_matrix_pkg::GLYPH_L2: rows = 64'h0000_3c7e_7e3c_0000;
            dot_matrix_pkg::GLYPH_L3: rows = 64'h003c_7e7e_7e7e_3c00;
            dot_matrix_pkg::GLYPH_L4: rows = 64'h3c7e_ffff_ffff_7e3c;
            dot_matrix_pkg::GLYPH_L5: rows = 64'hffff_ffff_ffff_ffff;
            dot_matrix_pkg::GLYPH_L6: rows = 64'hc3e3_f1e3_c7e7_f7fb;
            dot_matrix_pkg::GLYPH_L7: rows = 64'h0001_81c3_83c7_e7f3;
            default:                  rows = '0;
        endcase
        sh = 8 * (7 - int'(r));
        return rows[sh +: 8];
    endfunction

    // position of the low bit in the row drive
    function automatic dot_matrix_pkg::row_idx_t row_of(input dot_matrix_pkg::col_t r);
        dot_matrix_pkg::row_idx_t idx;
        idx = '0;
        for (int i = 0; i < `DM_ROWS; i++)
        begin
            if (!r[i])
                idx = dot_matrix_pkg::row_idx_t'(i);
        end
        return idx;
    endfunction

    // returns at the negedge after the panel switches to the target row
    task automatic wait_row(input dot_matrix_pkg::row_idx_t target);
        dot_matrix_pkg::col_t prev;
        int                   cycles;
        logic                 done;
        logic                 changed;
        prev   = row;
        cycles = 0;
        done   = 1'b0;
        while (!done)
        begin
            @(negedge clk);
            cycles++;
            changed = (row != prev);
            prev    = row;
            if (changed && row_of(row) == target)
                done = 1'b1;
            else if (cycles > wait_limit)
            begin
                $display("timeout: row %0d never came up within %0d cycles", target, wait_limit);
                stop_with_failure();
            end
        end
    endtask

    // reference model and compare
    // the DUT saw the inputs held since the last negedge
    always @(negedge clk)
    begin
        logic load_now;
        load_now = 1'b0;
        if (rst || rst_d)
        begin
            started = 1'b0;
            gap     = 0;
            exp_idx = dot_matrix_pkg::row_idx_t'(`DM_ROWS - 1);
            exp_row = '1;
            exp_g   = '0;
            exp_r   = '0;
            lvl_m   = '0;
        end
        else
        begin
            // first strobe is scan_div cycles after reset, rows follow one edge later
            gap++;
            if (gap == (started ? scan_div : scan_div + 1))
            begin
                load_now = 1'b1;
                started  = 1'b1;
                gap      = 0;
            end
            if (load_now)
            begin
                exp_idx = exp_idx + dot_matrix_pkg::row_idx_t'(1);
                exp_row = ~(dot_matrix_pkg::col_t'(1) << exp_idx);
            end
            if (!st_d)
            begin
                exp_g = '0;
                exp_r = '0;
                lvl_m = '0;
            end
            else
            begin
                if (load_now && exp_idx == '0)
                    lvl_m = num_d;  // new frame
                if (load_now)
                begin
                    exp_g = glyph_ref(lvl_m, exp_idx);
                    exp_r = temp_d ? exp_g : '0;
                end
                else if (!temp_d)
                    exp_r = '0;
            end
        end
        check_row("row", exp_row, row);
        check_cols("colg", exp_g, colg);
        check_cols("colr", exp_r, colr);
        check_level("frame_level", lvl_m, u_dut.u_glyph.frame_level);
        rst_d  = rst;
        st_d   = st;
        temp_d = temp;
        num_d  = num;
    end

    initial
    begin
        void'($urandom(32'h1199_94a5));
        rst  = 1'b1;
        st   = 1'b1;
        temp = 1'b0;
        num  = 4'd0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        // every level held over two frames
        for (int i = 0; i < 16; i++)
        begin
            wait_row(3'd7);
            @(posedge clk);
            num <= dot_matrix_pkg::level_t'(i);
            wait_row(3'd0);
            wait_row(3'd0);
        end

        // level changes mid-frame
        for (int i = 0; i < 24; i++)
        begin
            wait_row(dot_matrix_pkg::row_idx_t'($urandom_range(7, 1)));
            @(posedge clk);
            num <= dot_matrix_pkg::level_t'($urandom_range(15, 0));
        end

        // alarm on, then off mid-frame
        wait_row(3'd2);
        @(posedge clk);
        temp <= 1'b1;
        num  <= dot_matrix_pkg::level_t'($urandom_range(7, 0));
        wait_row(3'd0);
        wait_row(3'd0);
        wait_row(3'd4);
        @(posedge clk);
        temp <= 1'b0;
        wait_row(3'd0);

        // display off mid-frame with the alarm up
        wait_row(3'd1);
        @(posedge clk);
        temp <= 1'b1;
        num  <= 4'd4;
        wait_row(3'd0);
        wait_row(3'd3);
        @(posedge clk);
        st <= 1'b0;
        wait_row(3'd3);
        wait_row(3'd1);
        @(posedge clk);
        st  <= 1'b1;
        num <= 4'd6;  // shows from the next row 0
        wait_row(3'd0);
        wait_row(3'd0);
        @(posedge clk);
        temp <= 1'b0;
        wait_row(3'd0);

        $display("Simulation passed");
        $finish;
    end

endmodule
